// File: dv/pipe_alu_asserts.sv
// --------------------
// handshake and stall checks bound into pipe_alu_top
// all checks sample on the rising clock edge
// --------------------

module pipe_alu_asserts import pipe_alu_pkg::*; #(
	parameter int data_width = 16
) (
	input logic                  clk,
	input logic                  reset,
	input logic                  cke,
	input logic [data_width-1:0] m_result,
	input logic                  m_zero,
	input logic                  m_valid,
	input logic                  m_ready,
	input logic [alu_stages-1:0] stage_cke
);
	timeunit 1ns;
	timeprecision 1ps;

	// number of failed checks
	int fail_count = 0;

	// an offered result holds until it is taken
	a_result_hold: assert property (@(posedge clk) disable iff (reset)
		(m_valid && !(m_ready && cke)) |=>
			(m_valid && $stable(m_result) && $stable(m_zero)))
		else begin
			$error("result changed or dropped before it was taken");
			fail_count++;
		end

	// nothing leaves while reset is applied
	a_reset_quiet: assert property (@(posedge clk) reset |=> !m_valid)
		else begin
			$error("m_valid high during reset");
			fail_count++;
		end

	// stage enables are gated by cke
	a_stall: assert property (@(posedge clk) disable iff (reset)
		!cke |-> (stage_cke == '0))
		else begin
			$error("stage enable active while cke is low");
			fail_count++;
		end

endmodule

bind pipe_alu_top pipe_alu_asserts #(
	.data_width (data_width)
) u_asserts (
	.clk       (clk),
	.reset     (reset),
	.cke       (cke),
	.m_result  (m_result),
	.m_zero    (m_zero),
	.m_valid   (m_valid),
	.m_ready   (m_ready),
	.stage_cke (stage_cke)
);

// File: dv/pipe_alu_tb.sv
// --------------------
// random and directed traffic through pipe_alu_top
// data_width up to 32 as each LFSR draw is at most 32 bits
// expected results are queued in input order and popped per output
// --------------------

module pipe_alu_tb import pipe_alu_pkg::*; #(
	parameter int data_width      = 16,
	parameter bit master_in_regs  = 1,
	parameter bit master_out_regs = 1
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_items         = 400;
	localparam int watchdog_cycles = n_items * 20 + 10 * alu_stages;

	logic                  clk;
	logic                  reset;
	logic                  cke;
	logic [data_width-1:0] s_a;
	logic [data_width-1:0] s_b;
	alu_op_t               s_op;
	logic                  s_valid;
	logic                  s_ready;
	logic [data_width-1:0] m_result;
	logic                  m_zero;
	logic                  m_valid;
	logic                  m_ready;

	logic [15:0]           lfsr = 16'd11;
	logic                  run_stim;
	logic [data_width:0]   exp_q[$];
	logic [data_width:0]   exp_item;
	int                    sent;
	int                    n_in;
	int                    n_out;
	int                    err_value;
	int                    err_other;
	int                    err_assert;

	// values seen at the previous edge
	logic                  prev_cke = 1'b1;
	logic                  prev_valid;
	logic [data_width-1:0] prev_result;
	logic                  prev_zero;

	pipe_alu_top #(
		.data_width      (data_width),
		.master_in_regs  (master_in_regs),
		.master_out_regs (master_out_regs)
	) dut0 (
		.clk      (clk),
		.reset    (reset),
		.cke      (cke),
		.s_a      (s_a),
		.s_b      (s_b),
		.s_op     (s_op),
		.s_valid  (s_valid),
		.s_ready  (s_ready),
		.m_result (m_result),
		.m_zero   (m_zero),
		.m_valid  (m_valid),
		.m_ready  (m_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------
	// helpers
	// --------------------

	// fibonacci LFSR x^16+x^14+x^13+x^11+1 stepped once per bit
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// {zero, result} straight from the opcode rules
	function automatic logic [data_width:0] alu_model(input alu_op_t op,
			input logic [data_width-1:0] a, input logic [data_width-1:0] b);
		logic [2*data_width-1:0] prod;
		logic [data_width-1:0]   r;
		prod = a * b;
		case (op)
			op_add:  r = a + b;
			op_sub:  r = a + ~b + 1'b1;
			op_and:  r = a & b;
			op_or:   r = a | b;
			op_xor:  r = a ^ b;
			op_mul:  r = prod[data_width-1:0];
			default: r = '0;
		endcase
		return {(r == '0), r};
	endfunction

	task automatic check_result(input string name, input logic [data_width-1:0] exp,
			input logic [data_width-1:0] got);
		if (got !== exp) begin
			$display("error %s exp %h got %h", name, exp, got);
			err_value++;
		end
	endtask

	task automatic check_zero(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("error %s exp %h got %h", name, exp, got);
			err_value++;
		end
	endtask

	// first eight items are directed corner cases
	task automatic load_item(input int idx);
		logic [data_width-1:0] ra;
		logic [data_width-1:0] rb;
		alu_op_t               rop;
		ra  = next_bits(data_width);
		rb  = next_bits(data_width);
		rop = alu_op_t'(next_bits(3) % 6);
		case (idx)
			0: begin
				rb  = ra;
				rop = op_sub;
			end
			1: begin
				rb  = ra;
				rop = op_xor;
			end
			2: begin
				ra  = '0;
				rop = op_and;
			end
			3: begin
				rb  = '0;
				rop = op_mul;
			end
			4: begin
				ra  = '1;
				rb  = 1;
				rop = op_add;
			end
			5: begin
				ra  = '0;
				rb  = 1;
				rop = op_sub;
			end
			6: begin
				ra  = '1;
				rb  = '1;
				rop = op_mul;
			end
			7: begin
				ra  = {1'b1, {(data_width-1){1'b0}}};
				rb  = 2;
				rop = op_mul;
			end
			default: begin
				case (next_bits(2))
					0: rb = ra;
					1: ra = '0;
					default: ;
				endcase
			end
		endcase
		s_a  <= ra;
		s_b  <= rb;
		s_op <= rop;
	endtask

	// --------------------
	// stimulus and expected queue
	// --------------------

	always @(posedge clk) begin
		if (run_stim) begin
			if (s_valid && s_ready && cke) begin
				exp_q.push_back(alu_model(s_op, s_a, s_b));
				n_in++;
			end
			if (!s_valid || (s_ready && cke)) begin
				if (sent < n_items && next_bits(2) != 0) begin
					load_item(sent);
					s_valid <= 1'b1;
					sent++;
				end else begin
					s_valid <= 1'b0;
				end
			end
			// heavy back-pressure for a stretch so the pipe fills up
			if (sent > n_items / 3 && sent < n_items / 2) begin
				m_ready <= (next_bits(2) == 0);
			end else begin
				m_ready <= (next_bits(2) != 0);
			end
			cke <= (next_bits(3) != 0);
		end
	end

	// --------------------
	// compare
	// --------------------

	always @(posedge clk) begin
		if (!reset) begin
			if (m_valid && m_ready && cke) begin
				if (exp_q.size() == 0) begin
					$display("output transfer at %0t with no item outstanding", $time);
					err_other++;
				end else begin
					exp_item = exp_q.pop_front();
					check_result("m_result", exp_item[data_width-1:0], m_result);
					check_zero("m_zero", exp_item[data_width], m_zero);
				end
				n_out++;
			end
			// state frozen across an edge with cke low
			if (!prev_cke) begin
				check_zero("m_valid", prev_valid, m_valid);
				if (prev_valid) begin
					check_result("m_result", prev_result, m_result);
					check_zero("m_zero", prev_zero, m_zero);
				end
			end
			prev_cke    <= cke;
			prev_valid  <= m_valid;
			prev_result <= m_result;
			prev_zero   <= m_zero;
		end
	end

	// --------------------
	// main sequence
	// --------------------

	initial begin
		reset    <= 1'b1;
		cke      <= 1'b1;
		s_a      <= '0;
		s_b      <= '0;
		s_op     <= op_add;
		s_valid  <= 1'b0;
		m_ready  <= 1'b1;
		run_stim <= 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		repeat (2) @(posedge clk);
		if (s_ready !== 1'b1) begin
			$display("s_ready not high within two cycles of reset release");
			err_other++;
		end
		repeat (4) begin
			@(posedge clk);
			if (m_valid !== 1'b0) begin
				$display("m_valid went high after reset with no input");
				err_other++;
			end
		end
		run_stim <= 1'b1;
		while (n_out < n_items) @(posedge clk);
		repeat (10) @(posedge clk);
		if (exp_q.size() != 0 || n_in != n_items) begin
			$display("%0d items in, %0d out, %0d still queued", n_in, n_out, exp_q.size());
			err_other++;
		end
		err_assert = dut0.u_asserts.fail_count;
		$display("errors: %0d value, %0d other, %0d assertion",
			err_value, err_other, err_assert);
		if (err_value == 0 && err_other == 0 && err_assert == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		#(watchdog_cycles * 10);
		$display("timeout, %0d of %0d items came out", n_out, n_items);
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: pipe_alu_top.f
source/pipe_alu_pkg.sv
source/pipe_skid_buffer.sv
source/pipe_control.sv
source/pipe_alu_stages.sv
source/pipe_alu_top.sv
dv/pipe_alu_asserts.sv
dv/pipe_alu_tb.sv

// File: source/pipe_alu_pkg.sv
// --------------------
// shared types and constants for the pipelined ALU
// stage count is fixed by the datapath in pipe_alu_stages
// data width is a module parameter set at the top level
// --------------------

package pipe_alu_pkg;

	// --------------------
	// pipeline constants
	// --------------------

	// number of enabled register stages in the datapath
	localparam int alu_stages = 3;

	// opcode field width
	localparam int op_width = 3;

	// --------------------
	// opcodes
	// --------------------

	// codes 6 and 7 are unused, the ALU returns zero for them
	typedef enum logic [op_width-1:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_and = 3'd2,
		op_or  = 3'd3,
		op_xor = 3'd4,
		// low half of the product only
		op_mul = 3'd5
	} alu_op_t;

endpackage

// File: source/pipe_alu_stages.sv
// --------------------
// three-stage ALU datapath, each stage loads on its own enable
// stage 0 captures, stage 1 computes, stage 2 adds the zero flag
// arithmetic wraps at data_width, multiply keeps the low half
// only the opcode register is reset
// --------------------

module pipe_alu_stages import pipe_alu_pkg::*; #(
	parameter int data_width = 16
) (
	input  logic                  clk,
	input  logic                  reset,

	input  logic [alu_stages-1:0] stage_cke,

	input  logic [data_width-1:0] a,
	input  logic [data_width-1:0] b,
	input  alu_op_t               op,

	// {zero, result}
	output logic [data_width:0]   sink_data
);

	// --------------------
	// stage 0: operand capture
	// --------------------

	logic [data_width-1:0] s0_a;
	logic [data_width-1:0] s0_b;
	alu_op_t               s0_op;

	always_ff @(posedge clk) begin
		if (stage_cke[0]) begin
			s0_a <= a;
			s0_b <= b;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s0_op <= op_add;
		end else if (stage_cke[0]) begin
			s0_op <= op;
		end
	end

	// --------------------
	// stage 1: compute
	// --------------------

	logic [data_width-1:0] alu_out;
	logic [data_width-1:0] s1_result;

	// all results sized to data_width, so carries and high bits drop
	always_comb begin
		case (s0_op)
			op_add:  alu_out = s0_a + s0_b;
			op_sub:  alu_out = s0_a - s0_b;
			op_and:  alu_out = s0_a & s0_b;
			op_or:   alu_out = s0_a | s0_b;
			op_xor:  alu_out = s0_a ^ s0_b;
			op_mul:  alu_out = s0_a * s0_b;
			default: alu_out = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (stage_cke[1]) begin
			s1_result <= alu_out;
		end
	end

	// --------------------
	// stage 2: result and zero flag
	// --------------------

	logic [data_width-1:0] s2_result;
	logic                  s2_zero;

	always_ff @(posedge clk) begin
		if (stage_cke[2]) begin
			s2_result <= s1_result;
			s2_zero   <= (s1_result == '0);
		end
	end

	assign sink_data = {s2_zero, s2_result};

endmodule

// File: source/pipe_alu_top.sv
// --------------------
// pipelined integer ALU with valid/ready on both sides
// data_width must be 2 or more
// up to five items in flight: three stages and two buffer slots
// cke low freezes everything, nothing transfers
// --------------------

module pipe_alu_top import pipe_alu_pkg::*; #(
	parameter int data_width      = 16,
	parameter bit master_in_regs  = 1,
	parameter bit master_out_regs = 1
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cke,

	// operand side
	input  logic [data_width-1:0] s_a,
	input  logic [data_width-1:0] s_b,
	input  alu_op_t               s_op,
	input  logic                  s_valid,
	output logic                  s_ready,

	// result side
	output logic [data_width-1:0] m_result,
	output logic                  m_zero,
	output logic                  m_valid,
	input  logic                  m_ready
);

	logic [alu_stages-1:0] stage_cke;
	logic [data_width:0]   sink_data;
	logic [data_width:0]   m_data;

	pipe_control #(
		.data_width      (data_width),
		.master_in_regs  (master_in_regs),
		.master_out_regs (master_out_regs)
	) u_control (
		.clk       (clk),
		.reset     (reset),
		.cke       (cke),
		.s_valid   (s_valid),
		.s_ready   (s_ready),
		.stage_cke (stage_cke),
		.sink_data (sink_data),
		.m_data    (m_data),
		.m_valid   (m_valid),
		.m_ready   (m_ready)
	);

	pipe_alu_stages #(
		.data_width (data_width)
	) u_stages (
		.clk       (clk),
		.reset     (reset),
		.stage_cke (stage_cke),
		.a         (s_a),
		.b         (s_b),
		.op        (s_op),
		.sink_data (sink_data)
	);

	// zero flag rides in the top bit
	assign m_result = m_data[data_width-1:0];
	assign m_zero   = m_data[data_width];

endmodule

// File: source/pipe_control.sv
// --------------------
// stage enables and valid tracking for the ALU pipeline
// every stage keeps every item, so valids just shift forward
// master_in_regs=1: per-stage enables and s_ready come from flops
// master_in_regs=0: one shared enable, s_ready is combinational
// stage_cke is already gated with cke
// --------------------

module pipe_control import pipe_alu_pkg::*; #(
	parameter int data_width      = 16,
	parameter bit master_in_regs  = 1,
	parameter bit master_out_regs = 1
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cke,

	input  logic                  s_valid,
	output logic                  s_ready,

	output logic [alu_stages-1:0] stage_cke,
	input  logic [data_width:0]   sink_data,

	output logic [data_width:0]   m_data,
	output logic                  m_valid,
	input  logic                  m_ready
);

	localparam int last = alu_stages - 1;

	logic [alu_stages-1:0] stage_valid;
	logic [alu_stages-1:0] valid_next;

	// buffer ready now, and its predicted value for the next cycle
	logic buf_ready;
	logic buf_ready_next;

	// --------------------
	// valid chain
	// --------------------

	// an enabled stage takes whatever sits in front of it
	always_comb begin
		valid_next[0] = stage_cke[0] ? s_valid : stage_valid[0];
		for (int i = 1; i < alu_stages; i++) begin
			valid_next[i] = stage_cke[i] ? stage_valid[i-1] : stage_valid[i];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stage_valid <= '0;
		end else begin
			stage_valid <= valid_next;
		end
	end

	// --------------------
	// enable generation
	// --------------------

	generate
	if (master_in_regs) begin : g_registered
		logic [alu_stages-1:0] cke_reg;
		logic [alu_stages-1:0] cke_next;

		// enables for the next cycle, walking back from the buffer
		// a stage may move if the one after it moves or if it will be empty
		always_comb begin
			cke_next[last] = buf_ready_next || !valid_next[last];
			for (int i = last - 1; i >= 0; i--) begin
				cke_next[i] = cke_next[i+1] || !valid_next[i];
			end
		end

		always_ff @(posedge clk) begin
			if (reset) begin
				cke_reg <= '1;
			end else if (cke) begin
				cke_reg <= cke_next;
			end
		end

		assign stage_cke = cke_reg & {alu_stages{cke}};

		// stage 0 enable doubles as the registered ready
		assign s_ready = cke_reg[0];
	end else begin : g_combined
		logic shared_cke;

		// whole pipe moves when the tail is empty or the buffer takes it
		assign shared_cke = cke && (!stage_valid[last] || buf_ready);
		assign stage_cke  = {alu_stages{shared_cke}};
		assign s_ready    = shared_cke;
	end
	endgenerate

	// --------------------
	// output buffer
	// --------------------

	pipe_skid_buffer #(
		.width       (data_width + 1),
		.slave_regs  (master_in_regs),
		.master_regs (master_out_regs)
	) u_skid (
		.clk          (clk),
		.reset        (reset),
		.cke          (cke),
		.s_data       (sink_data),
		.s_valid      (stage_valid[last]),
		.s_ready      (buf_ready),
		.m_data       (m_data),
		.m_valid      (m_valid),
		.m_ready      (m_ready),
		.s_ready_next (buf_ready_next)
	);

endmodule

// File: source/pipe_skid_buffer.sv
// --------------------
// two-slot output buffer for a valid/ready stream
// slave_regs adds a skid slot so s_ready comes straight from a flop
// without slave_regs, s_ready_next mirrors the same-cycle s_ready
// master_regs adds a register on m_data and m_valid
// all state holds while cke is low
// --------------------

module pipe_skid_buffer #(
	parameter int width       = 17,
	parameter bit slave_regs  = 1,
	parameter bit master_regs = 1
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             cke,

	input  logic [width-1:0] s_data,
	input  logic             s_valid,
	output logic             s_ready,

	output logic [width-1:0] m_data,
	output logic             m_valid,
	input  logic             m_ready,

	output logic             s_ready_next
);

	// stream between the slave side and the master side
	logic [width-1:0] mid_data;
	logic             mid_valid;
	logic             mid_ready;

	// --------------------
	// slave side
	// --------------------

	generate
	if (slave_regs) begin : g_slave_regs
		logic [width-1:0] skid_data;
		logic             skid_valid;
		logic             skid_valid_next;

		// held item goes first, otherwise pass the input through
		assign mid_valid = skid_valid || s_valid;
		assign mid_data  = skid_valid ? skid_data : s_data;

		// an offered item that the master side does not take lands in the slot
		assign skid_valid_next = mid_valid && !mid_ready;

		// ready is simply "slot empty", so it is a flop output
		assign s_ready      = !skid_valid;
		assign s_ready_next = !skid_valid_next;

		always_ff @(posedge clk) begin
			if (reset) begin
				skid_valid <= 1'b0;
			end else if (cke) begin
				skid_valid <= skid_valid_next;
			end
		end

		// load while empty, the value only matters once skid_valid is set
		always_ff @(posedge clk) begin
			if (cke && !skid_valid) begin
				skid_data <= s_data;
			end
		end
	end else begin : g_slave_comb
		assign mid_valid    = s_valid;
		assign mid_data     = s_data;
		assign s_ready      = mid_ready;
		assign s_ready_next = mid_ready;
	end
	endgenerate

	// --------------------
	// master side
	// --------------------

	generate
	if (master_regs) begin : g_master_regs
		// accept when the output register is empty or being drained
		assign mid_ready = !m_valid || m_ready;

		always_ff @(posedge clk) begin
			if (reset) begin
				m_valid <= 1'b0;
			end else if (cke && mid_ready) begin
				m_valid <= mid_valid;
			end
		end

		always_ff @(posedge clk) begin
			if (cke && mid_ready && mid_valid) begin
				m_data <= mid_data;
			end
		end
	end else begin : g_master_comb
		assign mid_ready = m_ready;
		assign m_valid   = mid_valid;
		assign m_data    = mid_data;
	end
	endgenerate

endmodule
